// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_gb_io_hub
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_gb_io_hub.sv ====
`timescale 1ns/100ps

module tb_gb_io_hub;
	import gb_pkg::*;

	localparam int ACK_TIMEOUT = 16;  // cycles per bus access

	logic clk_cpu, reset;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	addr_t wb_adr;
	byte_t wb_dat_w, wb_dat_r;
	logic is_gbc;
	byte_t joystick;
	logic vblank_irq, lcd_irq, timer_irq;
	logic irq, irq_ack;
	byte_t irq_vector;

	int test_count, check_count, error_count, test_errors;
	byte_t ack_cycles;        // latency of the last access
	byte_t rd, joy;
	byte_t zp_data [0:126];
	byte_t wr_vals [0:15];
	addr_t wr_addrs [0:15];

	gb_io_hub gb_io_hub_inst (
		.clk_cpu (clk_cpu), .reset (reset),
		.wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
		.is_gbc (is_gbc), .joystick (joystick),
		.vblank_irq (vblank_irq), .lcd_irq (lcd_irq), .timer_irq (timer_irq),
		.irq (irq), .irq_vector (irq_vector), .irq_ack (irq_ack)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #4 clk_cpu = ~clk_cpu;  // 125 MHz
	end

	// --------------------------------------------------
	// helpers, all return 1 ns after a rising edge
	task automatic next_cycle();
		@(posedge clk_cpu);
		#1;
	endtask

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		check_count++;
		if (expected !== actual) begin
			$display("ERROR %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
		test_errors = 0;
	endtask

	task automatic wb_access(input logic we, input addr_t adr, input byte_t wdata,
			output byte_t rdata);
		int n;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		next_cycle();
		n = 1;
		while (!wb_ack) begin
			if (n >= ACK_TIMEOUT)
				abort_run("DUT never acked the bus access");
			next_cycle();
			n++;
		end
		ack_cycles = 8'(n);
		rdata  = wb_dat_r;  // stable through the ack cycle
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		next_cycle();       // ack drops here
	endtask

	task automatic wb_write(input addr_t adr, input byte_t data);
		byte_t unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input addr_t adr, output byte_t data);
		wb_access(1'b0, adr, 8'h00, data);
	endtask

	// poll IF until a flag shows up
	task automatic wait_if_flag(input int bit_idx, input int max_polls, input string what,
			output int polls);
		byte_t flags;
		polls = 0;
		wb_read(ADDR_IF, flags);
		while (!flags[bit_idx]) begin
			if (polls >= max_polls)
				abort_run(what);
			wb_read(ADDR_IF, flags);
			polls++;
		end
	endtask

	task automatic pulse_events(input logic v, input logic l, input logic t);
		vblank_irq = v;
		lcd_irq    = l;
		timer_irq  = t;
		next_cycle();
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
	endtask

	task automatic pulse_ack();
		irq_ack = 1'b1;
		next_cycle();
		irq_ack = 1'b0;
	endtask

	// expected joyp read, low select enables a group
	function automatic byte_t joyp_expect(input logic [1:0] sel, input byte_t j);
		logic [3:0] pressed;
		pressed = 4'b0000;
		if (!sel[0])
			pressed = pressed | {j[2], j[3], j[1], j[0]};  // right left up down
		if (!sel[1])
			pressed = pressed | j[7:4];                    // a b select start
		return {2'b11, sel, ~pressed};
	endfunction

	// --------------------------------------------------
	// directed tests
	task automatic test_reset_open_bus();
		addr_t addrs [0:6];
		byte_t exp [0:6];
		addrs = '{ADDR_IE, ADDR_IF, ADDR_SC, ADDR_JOYP, ADDR_SB, 16'hFE00, 16'hFF40};
		exp   = '{8'h00, 8'hE0, 8'h7E, 8'hCF, 8'hFF, 8'hFF, 8'hFF};  // IE top bits read 0
		for (int i = 0; i < 7; i++) begin
			wb_read(addrs[i], rd);
			check_byte("reset_open_bus", exp[i], rd);
			check_byte("reset_open_bus ack latency", 8'd1, ack_cycles);
		end
		check_byte("reset_open_bus irq", 8'd0, 8'(irq));
		finish_test("reset_open_bus");
	endtask

	task automatic test_zero_page_wram();
		for (int i = 0; i < 127; i++) begin
			zp_data[i] = 8'($urandom);
			wb_write(ZPRAM_BASE + 16'(i), zp_data[i]);
		end
		for (int i = 0; i < 127; i++) begin
			wb_read(ZPRAM_BASE + 16'(i), rd);
			check_byte("zero_page_wram zpram", zp_data[i], rd);
		end
		for (int i = 0; i < 16; i++) begin
			wr_addrs[i] = 16'hC000 + 16'(i) * 16'h0200 + (16'($urandom) & 16'h01FF);
			wr_vals[i]  = 8'($urandom);
			wb_write(wr_addrs[i], wr_vals[i]);
		end
		for (int i = 0; i < 16; i++) begin
			wb_read(wr_addrs[i], rd);
			check_byte("zero_page_wram wram", wr_vals[i], rd);
			if (i < 15) begin  // echo stops at fdff
				wb_read(wr_addrs[i] + 16'h2000, rd);
				check_byte("zero_page_wram echo", wr_vals[i], rd);
			end
		end
		finish_test("zero_page_wram");
	endtask

	task automatic test_colour_banking();
		is_gbc = 1'b1;
		wb_write(ADDR_SVBK, 8'h02);
		wb_write(16'hD000, 8'hA2);
		wb_write(16'hC000, 8'h5C);  // fixed bank 0
		wb_write(ADDR_SVBK, 8'h03);
		wb_write(16'hD000, 8'hB3);
		wb_read(16'hC000, rd);
		check_byte("colour_banking fixed", 8'h5C, rd);
		wb_read(16'hD000, rd);
		check_byte("colour_banking bank3", 8'hB3, rd);
		wb_write(ADDR_SVBK, 8'h02);
		wb_read(16'hD000, rd);
		check_byte("colour_banking bank2", 8'hA2, rd);
		wb_read(ADDR_SVBK, rd);
		check_byte("colour_banking svbk", 8'hFA, rd);
		wb_write(ADDR_SVBK, 8'h00);  // maps to 1
		wb_read(ADDR_SVBK, rd);
		check_byte("colour_banking svbk zero", 8'hF9, rd);
		is_gbc = 1'b0;
		wb_write(ADDR_SVBK, 8'h05);
		wb_read(ADDR_SVBK, rd);
		check_byte("colour_banking svbk dmg", 8'hFF, rd);
		is_gbc = 1'b1;
		wb_read(ADDR_SVBK, rd);
		check_byte("colour_banking write ignored", 8'hF9, rd);
		is_gbc = 1'b0;
		finish_test("colour_banking");
	endtask

	task automatic test_joypad();
		int polls;
		for (int sel = 0; sel < 4; sel++) begin
			for (int k = 0; k < 4; k++) begin
				joy      = 8'($urandom);
				joystick = joy;
				wb_write(ADDR_JOYP, {2'b00, 2'(sel), 4'h0});
				wb_read(ADDR_JOYP, rd);
				check_byte("joypad read", joyp_expect(2'(sel), joy), rd);
			end
		end
		// press right with only directions selected
		joystick = 8'h00;
		wb_write(ADDR_JOYP, 8'h20);
		repeat (4) next_cycle();  // let the synchroniser settle
		wb_write(ADDR_IF, 8'h00);
		joystick = 8'h01;
		wait_if_flag(IRQ_JOYPAD, 10, "joypad flag never set in IF", polls);
		joystick = 8'h00;
		wb_write(ADDR_JOYP, 8'h30);
		repeat (4) next_cycle();
		wb_write(ADDR_IF, 8'h00);
		finish_test("joypad");
	endtask

	task automatic test_irq_priority();
		wb_write(ADDR_IE, 8'h00);
		wb_write(ADDR_IF, 8'h00);
		pulse_events(1'b1, 1'b1, 1'b1);
		wb_read(ADDR_IF, rd);
		check_byte("irq_priority flags", 8'hE7, rd);
		check_byte("irq_priority gated", 8'd0, 8'(irq));
		wb_write(ADDR_IE, 8'h1F);
		check_byte("irq_priority irq", 8'd1, 8'(irq));
		check_byte("irq_priority vblank", 8'h40, irq_vector);
		pulse_ack();
		check_byte("irq_priority lcd", 8'h48, irq_vector);
		pulse_ack();
		check_byte("irq_priority timer", 8'h50, irq_vector);
		pulse_ack();
		check_byte("irq_priority none", 8'h55, irq_vector);
		check_byte("irq_priority idle", 8'd0, 8'(irq));
		// direct IF writes
		wb_write(ADDR_IF, 8'h0A);
		wb_read(ADDR_IF, rd);
		check_byte("irq_priority if set", 8'hEA, rd);
		check_byte("irq_priority if vector", 8'h48, irq_vector);  // lcd beats serial
		wb_write(ADDR_IF, 8'h00);
		check_byte("irq_priority if clear", 8'd0, 8'(irq));
		wb_write(ADDR_IE, 8'h00);
		finish_test("irq_priority");
	endtask

	task automatic test_serial();
		int polls;
		wb_write(ADDR_SC, 8'h81);
		wb_read(ADDR_SC, rd);
		check_byte("serial busy", 8'hFF, rd);
		wait_if_flag(IRQ_SERIAL, 4000, "serial transfer never finished", polls);  // ~4k cycles
		// 8 bits of 512 cycles, two cycles per poll
		check_byte("serial full length", 8'd1, 8'(polls >= 1800));
		wb_read(ADDR_SC, rd);
		check_byte("serial done", 8'h7F, rd);
		finish_test("serial");
	endtask

	// --------------------------------------------------
	initial begin
		reset      = 1'b1;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		is_gbc     = 1'b0;
		joystick   = '0;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
		irq_ack    = 1'b0;
		test_count  = 0;
		check_count = 0;
		error_count = 0;
		test_errors = 0;
		void'($urandom(97));
		repeat (4) @(posedge clk_cpu);
		#1 reset = 1'b0;

		test_reset_open_bus();
		test_zero_page_wram();
		test_colour_banking();
		test_joypad();
		test_irq_priority();
		test_serial();

		$display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== flist.f ====
rtl/gb_pkg.sv
rtl/bus_ctrl.sv
rtl/irq_ctrl.sv
rtl/joypad.sv
rtl/serial_port.sv
rtl/work_ram.sv
rtl/gb_io_hub.sv
dv/tb_gb_io_hub.sv

// ==== rtl/bus_ctrl.sv ====
`timescale 1ns/100ps

module bus_ctrl (
	input  logic          clk_cpu,
	input  logic          reset,
	input  logic          wb_cyc,
	input  logic          wb_stb,
	input  logic          wb_we,
	input  gb_pkg::addr_t wb_adr,
	input  gb_pkg::byte_t wb_dat_w,
	output gb_pkg::byte_t wb_dat_r,
	output logic          wb_ack,
	input  logic          is_gbc,
	output logic          joyp_we,
	output logic          sc_we,
	output logic          ie_we,
	output logic          if_we,
	output logic          svbk_we,
	output logic          wram_we,
	output logic          zpram_we,
	output gb_pkg::byte_t wr_data,
	output gb_pkg::addr_t ram_addr,
	input  gb_pkg::byte_t joyp_rd,
	input  gb_pkg::byte_t sc_rd,
	input  gb_pkg::byte_t ie_rd,
	input  gb_pkg::byte_t if_rd,
	input  gb_pkg::byte_t wram_rd,
	input  gb_pkg::byte_t zpram_rd,
	input  gb_pkg::wram_bank_t svbk_rd
);
	import gb_pkg::*;

	bus_state_t state;
	logic start;        // first cycle of a transfer
	logic wr_start;
	logic sel_wram, sel_zpram, sel_joyp, sel_sb, sel_sc;
	logic sel_if, sel_ie, sel_svbk;

	// --------------------------------------------------
	// wishbone slave, fixed two-cycle access
	assign start    = (state == BUS_IDLE) && wb_cyc && wb_stb;
	assign wr_start = start && wb_we;
	assign wb_ack   = (state == BUS_ACK);

	always_ff @(posedge clk_cpu) begin
		if (reset)
			state <= BUS_IDLE;
		else if (start)
			state <= BUS_ACK;
		else
			state <= BUS_IDLE; // ack lasts one cycle
	end

	// --------------------------------------------------
	// address decode
	assign sel_wram  = (wb_adr >= WRAM_BASE) && (wb_adr <= WRAM_END); // echo included
	assign sel_zpram = (wb_adr >= ZPRAM_BASE) && (wb_adr != ADDR_IE);
	assign sel_joyp  = (wb_adr == ADDR_JOYP);
	assign sel_sb    = (wb_adr == ADDR_SB);
	assign sel_sc    = (wb_adr == ADDR_SC);
	assign sel_if    = (wb_adr == ADDR_IF);
	assign sel_ie    = (wb_adr == ADDR_IE);
	assign sel_svbk  = (wb_adr == ADDR_SVBK);

	// single-cycle write strobes
	assign wram_we  = wr_start && sel_wram;
	assign zpram_we = wr_start && sel_zpram;
	assign joyp_we  = wr_start && sel_joyp;
	assign sc_we    = wr_start && sel_sc;
	assign if_we    = wr_start && sel_if;
	assign ie_we    = wr_start && sel_ie;
	assign svbk_we  = wr_start && sel_svbk && is_gbc; // dmg has no svbk

	assign wr_data  = wb_dat_w;
	assign ram_addr = wb_adr; // held by master until ack, so ram sees it both cycles

	// read mux, sampled by the master in the ack cycle
	always_comb begin
		wb_dat_r = OPEN_BUS;
		if (sel_wram)
			wb_dat_r = wram_rd;  // sync ram, valid in ack cycle
		else if (sel_zpram)
			wb_dat_r = zpram_rd;
		else if (sel_joyp)
			wb_dat_r = joyp_rd;
		else if (sel_sb)
			wb_dat_r = 8'hFF;    // no link partner
		else if (sel_sc)
			wb_dat_r = sc_rd;
		else if (sel_if)
			wb_dat_r = if_rd;
		else if (sel_ie)
			wb_dat_r = ie_rd;
		else if (sel_svbk && is_gbc)
			wb_dat_r = {5'h1F, svbk_rd};
	end

endmodule

// ==== rtl/gb_io_hub.sv ====
`timescale 1ns/100ps

module gb_io_hub (
	input  logic          clk_cpu,
	input  logic          reset,
	input  logic          wb_cyc,
	input  logic          wb_stb,
	input  logic          wb_we,
	input  gb_pkg::addr_t wb_adr,
	input  gb_pkg::byte_t wb_dat_w,
	output gb_pkg::byte_t wb_dat_r,
	output logic          wb_ack,
	input  logic          is_gbc,
	input  gb_pkg::byte_t joystick,
	input  logic          vblank_irq,
	input  logic          lcd_irq,
	input  logic          timer_irq,
	output logic          irq,
	output gb_pkg::byte_t irq_vector,
	input  logic          irq_ack
);
	import gb_pkg::*;

	// write strobes
	logic joyp_we, sc_we, ie_we, if_we, svbk_we, wram_we, zpram_we;
	byte_t wr_data;
	addr_t ram_addr;
	// read bytes back to the mux
	byte_t joyp_rd, sc_rd, ie_rd, if_rd, wram_rd, zpram_rd;
	wram_bank_t svbk_rd;
	logic joy_irq, serial_irq;

	bus_ctrl bus_ctrl_inst (
		.clk_cpu  (clk_cpu),  .reset    (reset),
		.wb_cyc   (wb_cyc),   .wb_stb   (wb_stb),   .wb_we    (wb_we),
		.wb_adr   (wb_adr),   .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),   .is_gbc   (is_gbc),
		.joyp_we  (joyp_we),  .sc_we    (sc_we),    .ie_we    (ie_we),
		.if_we    (if_we),    .svbk_we  (svbk_we),  .wram_we  (wram_we),
		.zpram_we (zpram_we), .wr_data  (wr_data),  .ram_addr (ram_addr),
		.joyp_rd  (joyp_rd),  .sc_rd    (sc_rd),    .ie_rd    (ie_rd),
		.if_rd    (if_rd),    .wram_rd  (wram_rd),  .zpram_rd (zpram_rd),
		.svbk_rd  (svbk_rd)
	);

	work_ram work_ram_inst (
		.clk_cpu  (clk_cpu),  .reset    (reset),    .is_gbc   (is_gbc),
		.ram_addr (ram_addr), .wr_data  (wr_data),
		.wram_we  (wram_we),  .zpram_we (zpram_we), .svbk_we  (svbk_we),
		.wram_rd  (wram_rd),  .zpram_rd (zpram_rd), .svbk_rd  (svbk_rd)
	);

	irq_ctrl irq_ctrl_inst (
		.clk_cpu    (clk_cpu),    .reset      (reset),     .wr_data   (wr_data),
		.ie_we      (ie_we),      .if_we      (if_we),
		.vblank_irq (vblank_irq), .lcd_irq    (lcd_irq),   .timer_irq (timer_irq),
		.serial_irq (serial_irq), .joy_irq    (joy_irq),   .irq_ack   (irq_ack),
		.ie_rd      (ie_rd),      .if_rd      (if_rd),
		.irq        (irq),        .irq_vector (irq_vector)
	);

	joypad joypad_inst (
		.clk_cpu (clk_cpu), .reset    (reset),    .wr_data (wr_data),
		.joyp_we (joyp_we), .joystick (joystick),
		.joyp_rd (joyp_rd), .joy_irq  (joy_irq)
	);

	serial_port serial_port_inst (
		.clk_cpu (clk_cpu), .reset (reset), .wr_data    (wr_data),
		.sc_we   (sc_we),   .sc_rd (sc_rd), .serial_irq (serial_irq)
	);

endmodule

// ==== rtl/gb_pkg.sv ====
package gb_pkg;

	// --------------------------------------------------
	// bus and storage widths
	typedef logic [15:0] addr_t;      // cpu bus address
	typedef logic [7:0]  byte_t;      // data byte
	typedef logic [4:0]  irq_mask_t;  // one bit per irq source
	typedef logic [14:0] wram_addr_t; // physical work ram address, 32K
	typedef logic [2:0]  wram_bank_t; // svbk bank number

	typedef enum logic [1:0] {
		SER_IDLE,
		SER_SHIFT,
		SER_DONE
	} ser_state_t;

	typedef enum logic {
		BUS_IDLE,
		BUS_ACK
	} bus_state_t;

	// --------------------------------------------------
	// memory map
	localparam addr_t ADDR_JOYP  = 16'hFF00;
	localparam addr_t ADDR_SB    = 16'hFF01;
	localparam addr_t ADDR_SC    = 16'hFF02;
	localparam addr_t ADDR_IF    = 16'hFF0F;
	localparam addr_t ADDR_SVBK  = 16'hFF70;
	localparam addr_t ADDR_IE    = 16'hFFFF;
	localparam addr_t WRAM_BASE  = 16'hC000; // incl. echo up to fdff
	localparam addr_t WRAM_END   = 16'hFDFF;
	localparam addr_t ZPRAM_BASE = 16'hFF80; // up to fffe

	// --------------------------------------------------
	// interrupt sources, lowest index wins
	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCD    = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	localparam byte_t IRQ_VEC_BASE = 8'h40;
	localparam int    IRQ_VEC_STEP = 8;
	localparam byte_t IRQ_VEC_NONE = 8'h55; // nothing pending

	// serial timing, 8192 Hz bit clock
	localparam int SERIAL_BIT_CYCLES = 512;
	localparam int SERIAL_BITS       = 8;

	localparam byte_t OPEN_BUS = 8'hFF;

endpackage

// ==== rtl/irq_ctrl.sv ====
`timescale 1ns/100ps

module irq_ctrl (
	input  logic          clk_cpu,
	input  logic          reset,
	input  gb_pkg::byte_t wr_data,
	input  logic          ie_we,
	input  logic          if_we,
	input  logic          vblank_irq,
	input  logic          lcd_irq,
	input  logic          timer_irq,
	input  logic          serial_irq,
	input  logic          joy_irq,
	input  logic          irq_ack,
	output gb_pkg::byte_t ie_rd,
	output gb_pkg::byte_t if_rd,
	output logic          irq,
	output gb_pkg::byte_t irq_vector
);
	import gb_pkg::*;

	irq_mask_t ie_r;
	irq_mask_t if_r;
	irq_mask_t events;   // this cycle's event pulses
	irq_mask_t pending;  // enabled and flagged
	irq_mask_t ack_clr;  // lowest pending bit, one-hot

	always_comb begin
		events             = '0;
		events[IRQ_VBLANK] = vblank_irq;
		events[IRQ_LCD]    = lcd_irq;
		events[IRQ_TIMER]  = timer_irq;
		events[IRQ_SERIAL] = serial_irq;
		events[IRQ_JOYPAD] = joy_irq;
	end

	assign pending = ie_r & if_r;
	assign irq     = |pending;
	assign ack_clr = pending & (~pending + irq_mask_t'(1)); // isolate lowest set bit

	// walk down so the lowest index wins
	always_comb begin
		irq_vector = IRQ_VEC_NONE;
		for (int i = IRQ_JOYPAD; i >= IRQ_VBLANK; i--) begin
			if (pending[i])
				irq_vector = byte_t'(IRQ_VEC_BASE + i * IRQ_VEC_STEP);
		end
	end

	// --------------------------------------------------
	// IE / IF registers
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			ie_r <= '0;
			if_r <= '0;
		end else begin
			if (ie_we)
				ie_r <= wr_data[4:0];
			if (if_we)
				if_r <= wr_data[4:0]; // cpu write overrides events and ack
			else if (irq_ack)
				if_r <= (if_r & ~ack_clr) | events;
			else
				if_r <= if_r | events;
		end
	end

	assign ie_rd = {3'b000, ie_r};
	assign if_rd = {3'b111, if_r}; // unused bits read high

endmodule

// ==== rtl/joypad.sv ====
`timescale 1ns/100ps

module joypad (
	input  logic          clk_cpu,
	input  logic          reset,
	input  gb_pkg::byte_t wr_data,
	input  logic          joyp_we,
	input  gb_pkg::byte_t joystick,
	output gb_pkg::byte_t joyp_rd,
	output logic          joy_irq
);

	logic [1:0] line_sel;   // p15/p14, low selects
	logic [3:0] dir_n;      // right left up down, active low
	logic [3:0] btn_n;      // a b select start, active low
	logic [7:0] line_q1, line_q2;

	assign dir_n = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{line_sel[0]}};
	assign btn_n = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{line_sel[1]}};

	assign joyp_rd = {2'b11, line_sel, dir_n & btn_n};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			line_sel <= 2'b00;
			line_q1  <= '1;  // idle lines are high
			line_q2  <= '1;
			joy_irq  <= 1'b0;
		end else begin
			if (joyp_we)
				line_sel <= wr_data[5:4];
			line_q1 <= {btn_n, dir_n};
			line_q2 <= line_q1;
			joy_irq <= |(line_q2 & ~line_q1); // any line fell
		end
	end

endmodule

// ==== rtl/serial_port.sv ====
`timescale 1ns/100ps

module serial_port (
	input  logic          clk_cpu,
	input  logic          reset,
	input  gb_pkg::byte_t wr_data,
	input  logic          sc_we,
	output gb_pkg::byte_t sc_rd,
	output logic          serial_irq
);
	import gb_pkg::*;

	ser_state_t state;
	logic sc_start;  // bit 7, transfer in progress
	logic sc_clk;    // bit 0, internal clock
	logic [$clog2(SERIAL_BIT_CYCLES)-1:0] div_cnt;
	logic [$clog2(SERIAL_BITS)-1:0]       bit_cnt;
	logic bit_end;

	assign bit_end = (div_cnt == ($clog2(SERIAL_BIT_CYCLES))'(SERIAL_BIT_CYCLES - 1));
	assign sc_rd   = {sc_start, 6'h3F, sc_clk};

	// --------------------------------------------------
	// dummy transfer, nothing is shifted out
	always_ff @(posedge clk_cpu) begin
		serial_irq <= 1'b0;
		if (reset) begin
			state    <= SER_IDLE;
			sc_start <= 1'b0;
			sc_clk   <= 1'b0;
		end else if (sc_we) begin
			sc_start <= wr_data[7];
			sc_clk   <= wr_data[0];
			state    <= SER_IDLE;   // restart on any write
		end else begin
			case (state)
				SER_IDLE: begin
					div_cnt <= '0;
					bit_cnt <= '0;
					if (sc_start && sc_clk)
						state <= SER_SHIFT; // external clock never arrives
				end
				SER_SHIFT: begin
					div_cnt <= div_cnt + 1'b1;
					if (bit_end) begin
						div_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == ($clog2(SERIAL_BITS))'(SERIAL_BITS - 1))
							state <= SER_DONE;
					end
				end
				SER_DONE: begin
					sc_start   <= 1'b0;
					serial_irq <= 1'b1;     // one pulse per byte
					state      <= SER_IDLE;
				end
				default: state <= SER_IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/work_ram.sv ====
`timescale 1ns/100ps

module work_ram (
	input  logic               clk_cpu,
	input  logic               reset,
	input  logic               is_gbc,
	input  gb_pkg::addr_t      ram_addr,
	input  gb_pkg::byte_t      wr_data,
	input  logic               wram_we,
	input  logic               zpram_we,
	input  logic               svbk_we,
	output gb_pkg::byte_t      wram_rd,
	output gb_pkg::byte_t      zpram_rd,
	output gb_pkg::wram_bank_t svbk_rd
);
	import gb_pkg::*;

	byte_t wram_mem [0:32767];  // 8 banks of 4K
	byte_t zpram_mem [0:127];   // ff80-fffe, top byte unused

	wram_bank_t bank_r;
	wram_bank_t bank_eff;
	wram_addr_t wram_addr;

	// --------------------------------------------------
	// svbk, bank 0 can't be mapped high
	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank_r <= 3'd1;
		else if (svbk_we) begin
			if (wr_data[2:0] == 3'd0)
				bank_r <= 3'd1;
			else
				bank_r <= wr_data[2:0];
		end
	end

	assign svbk_rd  = bank_r;
	assign bank_eff = is_gbc ? bank_r : 3'd1; // dmg sees a flat 8K

	// c000-cfff fixed bank 0, d000-dfff switchable
	assign wram_addr = ram_addr[12] ? {bank_eff, ram_addr[11:0]}
	                                : {3'd0, ram_addr[11:0]};

	// --------------------------------------------------
	// sync read, data in the ack cycle
	always_ff @(posedge clk_cpu) begin
		if (wram_we)
			wram_mem[wram_addr] <= wr_data;
		wram_rd <= wram_mem[wram_addr];
	end

	always_ff @(posedge clk_cpu) begin
		if (zpram_we)
			zpram_mem[ram_addr[6:0]] <= wr_data;
		zpram_rd <= zpram_mem[ram_addr[6:0]];
	end

endmodule
